// File: hop_codes.mem
// one 16-bit hop code in hex per line, hop 0 first.
a5c3
3c96
0ff0
9e17
5a5a
c381
7e24
e60b

// File: project.f
design/hop_tx_pkg.sv
design/scan_bus_if.sv
design/tick_divider.sv
design/scan_shifter.sv
design/tone_gen.sv
design/hop_sequencer.sv
design/gpio_port.sv
design/hop_tx_top.sv
bench/hop_tx_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module hop_tx_tb -f project.f -o hop_tx_sim

./obj_dir/hop_tx_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// File: bench/hop_tx_tb.sv
`timescale 1ns/10ps

module hop_tx_tb;

  logic                                   clk = 1'b0;
  logic                                   reset;
  logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_in;
  logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_out;
  logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_ddr;
  logic        [hop_tx_pkg::NSYMB-1:0]    tx_bits;
  logic signed [hop_tx_pkg::SAMPLE_W-1:0] itx;
  logic signed [hop_tx_pkg::SAMPLE_W-1:0] qtx;
  logic                                   tx_valid;

  logic [hop_tx_pkg::HOP_CODE_W-1:0] codes [hop_tx_pkg::NUM_HOPS];
  logic [hop_tx_pkg::HOP_CODE_W-1:0] shreg = '0;     // last scan bits seen on the pins.
  logic [hop_tx_pkg::GPIO_W-1:0]     prev_out = '0;
  logic [hop_tx_pkg::HOP_IDX_W-1:0]  cur_hop = '0;
  logic [hop_tx_pkg::PHASE_W-1:0]    ph;
  logic [3:0]                        sin_idx;
  logic [3:0]                        cos_idx;
  logic                              prev_valid = 1'b0;
  integer                            seed = 32'h6d034e37;
  int                                bursts = 0;
  int                                gap = 0;
  int                                sample_idx = 0;
  int                                nbits = 0;
  int                                loads = 0;

  hop_tx_top hop_tx_top_inst (
    .clk         (clk),
    .reset       (reset),
    .fp_gpio_in  (fp_gpio_in),
    .fp_gpio_out (fp_gpio_out),
    .fp_gpio_ddr (fp_gpio_ddr),
    .tx_bits     (tx_bits),
    .itx         (itx),
    .qtx         (qtx),
    .tx_valid    (tx_valid)
  );

  always #50 clk = ~clk;

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic wait_valid(input logic level, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (tx_valid !== level && cycles < limit) begin
      cycles++;
      @(negedge clk);
    end
    if (tx_valid !== level) begin
      report_error($sformatf("tx_valid did not go to %0d within %0d cycles", level, limit));
    end
  endtask

  task automatic wait_load(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((fp_gpio_out & hop_tx_pkg::PIN_LOAD) == '0 && cycles < limit) begin
      cycles++;
      @(negedge clk);
    end
    if ((fp_gpio_out & hop_tx_pkg::PIN_LOAD) == '0) begin
      report_error($sformatf("no load_chip pulse within %0d cycles", limit));
    end
  endtask

  // output phase of sample n in the burst of the given hop.
  function automatic logic [hop_tx_pkg::PHASE_W-1:0] burst_phase(
    input logic [hop_tx_pkg::HOP_IDX_W-1:0] hop,
    input int                               n,
    input logic [hop_tx_pkg::NSYMB-1:0]     bits
  );
    logic [hop_tx_pkg::SYMB_IDX_W-1:0] sym;
    logic [hop_tx_pkg::PHASE_W-1:0]    p;
    sym = hop_tx_pkg::SYMB_IDX_W'(n / hop_tx_pkg::SYMB_LEN);
    p   = hop_tx_pkg::PHASE_W'(n * (int'(hop_tx_pkg::HOP_BASE_INC) +
                                    int'(hop) * int'(hop_tx_pkg::HOP_STEP_INC)));
    if (sym == '0) begin
      p = p + hop_tx_pkg::PILOT_PH;
    end else if (bits[sym]) begin
      p = p + hop_tx_pkg::BIT_PH;
    end
    return p;
  endfunction

  assert property (@(posedge clk) disable iff (reset)
    (fp_gpio_out & (hop_tx_pkg::PIN_PHI | hop_tx_pkg::PIN_PHI_BAR)) !=
    (hop_tx_pkg::PIN_PHI | hop_tx_pkg::PIN_PHI_BAR))
    else report_error($sformatf("Error: fp_gpio_out has phi and phi_bar high, 0x%h",
                                $sampled(fp_gpio_out)));

  assert property (@(posedge clk) disable iff (reset)
    !(tx_valid && (fp_gpio_out & hop_tx_pkg::PIN_SYNC) != '0))
    else report_error($sformatf("Error: fp_gpio_out sync pin high with tx_valid, 0x%h",
                                $sampled(fp_gpio_out)));

  assert property (@(posedge clk) disable iff (reset)
    tx_valid || (itx == '0 && qtx == '0))
    else report_error($sformatf("Error: itx 0x%h qtx 0x%h while tx_valid is low",
                                $sampled(itx), $sampled(qtx)));

  always @(negedge clk) begin
    if (!reset) begin
      if (tx_valid && !prev_valid) begin
        if (bursts % hop_tx_pkg::NUM_HOPS == 0 && bursts > 0) begin
          assert (gap > hop_tx_pkg::SYNC_LEN + 1)
            else report_error($sformatf("Error: tx_valid gap 0x%h, expected above 0x%h",
                                        gap, hop_tx_pkg::SYNC_LEN + 1));
        end else if (bursts > 0) begin
          assert (gap == hop_tx_pkg::SYNC_LEN + 1)
            else report_error($sformatf("Error: tx_valid gap 0x%h, expected 0x%h",
                                        gap, hop_tx_pkg::SYNC_LEN + 1));
        end
        cur_hop    = hop_tx_pkg::HOP_IDX_W'(bursts % hop_tx_pkg::NUM_HOPS);
        bursts     = bursts + 1;
        sample_idx = 0;
      end
      if (tx_valid) begin
        ph      = burst_phase(cur_hop, sample_idx, tx_bits);
        sin_idx = ph[hop_tx_pkg::PHASE_W-1 -: 4];
        cos_idx = sin_idx + 4'd4;              // quarter turn ahead.
        assert (itx == hop_tx_pkg::SINE_LUT[cos_idx])
          else report_error($sformatf("Error: itx 0x%h, expected 0x%h (hop %0d, sample %0d)",
                                      itx, hop_tx_pkg::SINE_LUT[cos_idx], cur_hop, sample_idx));
        assert (qtx == hop_tx_pkg::SINE_LUT[sin_idx])
          else report_error($sformatf("Error: qtx 0x%h, expected 0x%h (hop %0d, sample %0d)",
                                      qtx, hop_tx_pkg::SINE_LUT[sin_idx], cur_hop, sample_idx));
        sample_idx = sample_idx + 1;
        gap        = 0;
      end else begin
        gap = gap + 1;
      end
      if (!tx_valid && prev_valid) begin
        assert (sample_idx == hop_tx_pkg::BURST_LEN)
          else report_error($sformatf("Error: tx_valid burst of 0x%h samples, expected 0x%h",
                                      sample_idx, hop_tx_pkg::BURST_LEN));
      end
      if ((fp_gpio_out & hop_tx_pkg::PIN_PHI) != '0 && (prev_out & hop_tx_pkg::PIN_PHI) == '0) begin
        shreg = {shreg[hop_tx_pkg::HOP_CODE_W-2:0], (fp_gpio_out & hop_tx_pkg::PIN_DATA) != '0};
        nbits = nbits + 1;
      end
      // a load follows exactly one whole hop code.
      if ((fp_gpio_out & hop_tx_pkg::PIN_LOAD) != '0 && (prev_out & hop_tx_pkg::PIN_LOAD) == '0) begin
        assert (nbits == hop_tx_pkg::HOP_CODE_W)
          else report_error($sformatf("Error: scan bits before load_chip 0x%h, expected 0x%h",
                                      nbits, hop_tx_pkg::HOP_CODE_W));
        assert (shreg == codes[cur_hop])
          else report_error($sformatf("Error: fp_gpio_out scan data 0x%h, expected 0x%h",
                                      shreg, codes[cur_hop]));
        loads = loads + 1;
        nbits = 0;
      end
      // a new hop code starts shifting after the sync pin rises.
      if ((fp_gpio_out & hop_tx_pkg::PIN_SYNC) != '0 &&
          (prev_out & hop_tx_pkg::PIN_SYNC) == '0) begin
        nbits = 0;
      end
      prev_valid = tx_valid;
      prev_out   = fp_gpio_out;
    end
  end

  initial begin
    reset      = 1'b1;
    fp_gpio_in = '0;
    tx_bits    = '0;
    $readmemh("hop_codes.mem", codes);
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (200) begin
      @(negedge clk);
      assert (fp_gpio_ddr == hop_tx_pkg::OUT_MASK)
        else report_error($sformatf("Error: fp_gpio_ddr 0x%h, expected 0x%h",
                                    fp_gpio_ddr, hop_tx_pkg::OUT_MASK));
      assert (fp_gpio_out == '0)
        else report_error($sformatf("Error: fp_gpio_out 0x%h, expected 0x000", fp_gpio_out));
      assert (!tx_valid)
        else report_error($sformatf("Error: tx_valid 0x%h, expected 0x0", tx_valid));
    end
    for (int b = 0; b < 2 * hop_tx_pkg::NUM_HOPS; b++) begin
      @(posedge clk);
      tx_bits <= hop_tx_pkg::NSYMB'($random(seed));
      if (b == 0) begin
        fp_gpio_in <= hop_tx_pkg::PIN_ARM;
      end else if (b == 2 * hop_tx_pkg::NUM_HOPS - 1) begin
        fp_gpio_in <= '0;                      // second pass ends in idle.
      end
      wait_valid(1'b1, 300);
      wait_valid(1'b0, 300);
    end
    wait_load(400);
    @(posedge clk);
    if (bursts == 2 * hop_tx_pkg::NUM_HOPS && loads == 1) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_error($sformatf("run ended with %0d bursts and %0d code loads", bursts, loads));
    end
  end

endmodule

// File: design/hop_tx_top.sv
`timescale 1ns/10ps

module hop_tx_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_in,
  output logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_out,
  output logic        [hop_tx_pkg::GPIO_W-1:0]   fp_gpio_ddr,
  input  logic        [hop_tx_pkg::NSYMB-1:0]    tx_bits,
  output logic signed [hop_tx_pkg::SAMPLE_W-1:0] itx,
  output logic signed [hop_tx_pkg::SAMPLE_W-1:0] qtx,
  output logic                                   tx_valid
);

  logic                              scan_tick;
  logic                              code_start;
  logic [hop_tx_pkg::HOP_CODE_W-1:0] hop_code;
  logic                              burst_start;
  logic [hop_tx_pkg::PHASE_W-1:0]    phase_inc;
  logic                              burst_done;
  logic                              sync_active;
  logic                              tx_active;
  logic                              arm;

  scan_bus_if scan ();

  tick_divider tick_divider_inst (
    .clk   (clk),
    .reset (reset),
    .tick  (scan_tick)
  );

  scan_shifter scan_shifter_inst (
    .clk        (clk),
    .reset      (reset),
    .tick       (scan_tick),
    .code_start (code_start),
    .hop_code   (hop_code),
    .scan       (scan.driver)
  );

  tone_gen tone_gen_inst (
    .clk         (clk),
    .reset       (reset),
    .burst_start (burst_start),
    .phase_inc   (phase_inc),
    .tx_bits     (tx_bits),
    .itx         (itx),
    .qtx         (qtx),
    .tx_valid    (tx_valid),
    .burst_done  (burst_done)
  );

  hop_sequencer hop_sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .arm         (arm),
    .burst_done  (burst_done),
    .code_start  (code_start),
    .hop_code    (hop_code),
    .burst_start (burst_start),
    .phase_inc   (phase_inc),
    .sync_active (sync_active),
    .tx_active   (tx_active)
  );

  gpio_port gpio_port_inst (
    .clk         (clk),
    .reset       (reset),
    .fp_gpio_in  (fp_gpio_in),
    .fp_gpio_out (fp_gpio_out),
    .fp_gpio_ddr (fp_gpio_ddr),
    .scan        (scan.pins),
    .sync_active (sync_active),
    .tx_active   (tx_active),
    .arm         (arm)
  );

endmodule

// File: design/gpio_port.sv
`timescale 1ns/10ps

module gpio_port (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_in,
  output logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_out,
  output logic [hop_tx_pkg::GPIO_W-1:0] fp_gpio_ddr,
  scan_bus_if.pins                      scan,
  input  logic                          sync_active,
  input  logic                          tx_active,
  output logic                          arm
);

  logic [hop_tx_pkg::GPIO_W-1:0] in_meta;
  logic [hop_tx_pkg::GPIO_W-1:0] in_sync;
  logic [hop_tx_pkg::GPIO_W-1:0] out_word;

  assign arm         = |(in_sync & hop_tx_pkg::PIN_ARM);
  assign fp_gpio_ddr = hop_tx_pkg::OUT_MASK;   // fixed directions.

  always_comb begin
    out_word = '0;
    if (scan.id)        out_word = out_word | hop_tx_pkg::PIN_ID;
    if (scan.phi)       out_word = out_word | hop_tx_pkg::PIN_PHI;
    if (scan.phi_bar)   out_word = out_word | hop_tx_pkg::PIN_PHI_BAR;
    if (scan.data)      out_word = out_word | hop_tx_pkg::PIN_DATA;
    if (scan.load_chip) out_word = out_word | hop_tx_pkg::PIN_LOAD;
    if (sync_active)    out_word = out_word | hop_tx_pkg::PIN_SYNC;
    if (tx_active)      out_word = out_word | hop_tx_pkg::PIN_TX;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      in_meta     <= '0;
      in_sync     <= '0;
      fp_gpio_out <= '0;
    end else begin
      in_meta     <= fp_gpio_in;           // two-stage synchronizer.
      in_sync     <= in_meta;
      fp_gpio_out <= out_word & hop_tx_pkg::OUT_MASK;
    end
  end

endmodule

// File: design/hop_sequencer.sv
`timescale 1ns/10ps

module hop_sequencer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              arm,
  input  logic                              burst_done,
  output logic                              code_start,
  output logic [hop_tx_pkg::HOP_CODE_W-1:0] hop_code,
  output logic                              burst_start,
  output logic [hop_tx_pkg::PHASE_W-1:0]    phase_inc,
  output logic                              sync_active,
  output logic                              tx_active
);

  hop_tx_pkg::seq_state_t state;

  logic [hop_tx_pkg::SYNC_CNT_W-1:0] count;    // shared by both sync states.
  logic [hop_tx_pkg::HOP_IDX_W-1:0]  hop_idx;
  logic [hop_tx_pkg::HOP_CODE_W-1:0] code_table [hop_tx_pkg::NUM_HOPS];

  initial begin
    $readmemh("hop_codes.mem", code_table);
  end

  assign hop_code    = code_table[hop_idx];
  assign code_start  = (state == hop_tx_pkg::st_hop_sync) && (count == hop_tx_pkg::SYNC_LAST);
  assign burst_start = (state == hop_tx_pkg::st_hop_sync) && (count == '0);
  assign tx_active   = (state == hop_tx_pkg::st_hop_tx);

  // the sync pin is registered one cycle later than tx_valid rises,
  // so drop the flag on the burst_start cycle to keep them apart.
  assign sync_active = ((state == hop_tx_pkg::st_loc_sync) ||
                        (state == hop_tx_pkg::st_hop_sync)) && !burst_start;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= hop_tx_pkg::st_init;
      count     <= '0;
      hop_idx   <= '0;
      phase_inc <= hop_tx_pkg::HOP_BASE_INC;
    end else begin
      case (state)
        hop_tx_pkg::st_init: begin
          hop_idx   <= '0;
          phase_inc <= hop_tx_pkg::HOP_BASE_INC;
          count     <= hop_tx_pkg::LOC_SYNC_LAST;
          if (arm) begin
            state <= hop_tx_pkg::st_loc_sync;
          end
        end
        hop_tx_pkg::st_loc_sync: begin
          if (count == '0) begin
            state <= hop_tx_pkg::st_hop_sync;
            count <= hop_tx_pkg::SYNC_LAST;
          end else begin
            count <= count - 1'b1;
          end
        end
        hop_tx_pkg::st_hop_sync: begin
          if (count == '0) begin
            state <= hop_tx_pkg::st_hop_tx;
          end else begin
            count <= count - 1'b1;
          end
        end
        hop_tx_pkg::st_hop_tx: begin
          if (burst_done) begin
            if (hop_idx == hop_tx_pkg::LAST_HOP) begin
              state <= hop_tx_pkg::st_init;   // pass done, wait for arm again.
            end else begin
              state     <= hop_tx_pkg::st_hop_sync;
              count     <= hop_tx_pkg::SYNC_LAST;
              hop_idx   <= hop_idx + 1'b1;
              phase_inc <= phase_inc + hop_tx_pkg::HOP_STEP_INC;
            end
          end
        end
        default: begin
          state <= hop_tx_pkg::st_init;
        end
      endcase
    end
  end

endmodule

// File: design/tone_gen.sv
`timescale 1ns/10ps

module tone_gen (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   burst_start,
  input  logic        [hop_tx_pkg::PHASE_W-1:0]  phase_inc,
  input  logic        [hop_tx_pkg::NSYMB-1:0]    tx_bits,
  output logic signed [hop_tx_pkg::SAMPLE_W-1:0] itx,
  output logic signed [hop_tx_pkg::SAMPLE_W-1:0] qtx,
  output logic                                   tx_valid,
  output logic                                   burst_done
);

  logic [hop_tx_pkg::PHASE_W-1:0]      acc;       // phase of the next sample.
  logic [hop_tx_pkg::PHASE_W-1:0]      inc_q;
  logic [hop_tx_pkg::PHASE_W-1:0]      inc_sel;
  logic [hop_tx_pkg::PHASE_W-1:0]      base_ph;
  logic [hop_tx_pkg::PHASE_W-1:0]      sym_ph;
  logic [hop_tx_pkg::PHASE_W-1:0]      out_ph;
  logic [hop_tx_pkg::SAMPLE_IDX_W-1:0] idx;
  logic [hop_tx_pkg::SAMPLE_IDX_W-1:0] cur_idx;
  logic [hop_tx_pkg::SYMB_IDX_W-1:0]   sym;
  logic [hop_tx_pkg::LUT_W-1:0]        sin_i;
  logic [hop_tx_pkg::LUT_W-1:0]        cos_i;
  logic                                active;
  logic                                emit;

  // sample 0 goes out on the burst_start edge itself.
  assign emit    = burst_start | active;
  assign cur_idx = burst_start ? '0 : idx;
  assign base_ph = burst_start ? '0 : acc;
  assign inc_sel = burst_start ? phase_inc : inc_q;

  assign sym = cur_idx[hop_tx_pkg::SYMB_SHIFT +: hop_tx_pkg::SYMB_IDX_W];

  always_comb begin
    if (sym == '0) begin
      sym_ph = hop_tx_pkg::PILOT_PH;
    end else if (tx_bits[sym]) begin
      sym_ph = hop_tx_pkg::BIT_PH;
    end else begin
      sym_ph = '0;
    end
  end

  assign out_ph = base_ph + sym_ph;
  assign sin_i  = out_ph[hop_tx_pkg::PHASE_W-1 -: hop_tx_pkg::LUT_W];
  assign cos_i  = sin_i + hop_tx_pkg::QUARTER_IDX;   // wraps in 4 bits.

  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      idx        <= '0;
      tx_valid   <= 1'b0;
      burst_done <= 1'b0;
    end else begin
      tx_valid   <= emit;
      burst_done <= tx_valid & ~emit;
      if (emit) begin
        active <= (cur_idx != hop_tx_pkg::BURST_LAST);
        idx    <= cur_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (burst_start) begin
      inc_q <= phase_inc;
    end
    if (emit) begin
      acc <= base_ph + inc_sel;
      itx <= hop_tx_pkg::SINE_LUT[cos_i];
      qtx <= hop_tx_pkg::SINE_LUT[sin_i];
    end else begin
      itx <= '0;
      qtx <= '0;
    end
  end

endmodule

// File: design/scan_shifter.sv
`timescale 1ns/10ps

module scan_shifter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              tick,
  input  logic                              code_start,
  input  logic [hop_tx_pkg::HOP_CODE_W-1:0] hop_code,
  scan_bus_if.driver                        scan
);

  logic [hop_tx_pkg::HOP_CODE_W-1:0]  sreg;
  logic [hop_tx_pkg::SCAN_STEP_W-1:0] step;   // bit index in upper bits, phase in [1:0].
  logic                               pending;
  logic                               running;
  logic                               in_bits;
  logic                               bit_end;

  assign in_bits = (step < hop_tx_pkg::SCAN_BIT_STEPS);
  assign bit_end = running && in_bits && (step[1:0] == 2'd3);

  // code_start wins over everything, a new code restarts the transfer.
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      running <= 1'b0;
      step    <= '0;
    end else if (code_start) begin
      pending <= 1'b1;
      running <= 1'b0;
      step    <= '0;
    end else if (tick) begin
      if (pending) begin
        pending <= 1'b0;      // line up with the scan tick grid.
        running <= 1'b1;
        step    <= '0;
      end else if (running) begin
        if (step == hop_tx_pkg::SCAN_LAST_STEP) begin
          running <= 1'b0;
          step    <= '0;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (code_start) begin
      sreg <= hop_code;
    end else if (tick && bit_end) begin
      sreg <= {sreg[hop_tx_pkg::HOP_CODE_W-2:0], 1'b0}; // msb first.
    end
  end

  // phases per bit: phi, gap, phi_bar, gap.
  assign scan.id        = pending | running;
  assign scan.phi       = running && in_bits && (step[1:0] == 2'd0);
  assign scan.phi_bar   = running && in_bits && (step[1:0] == 2'd2);
  assign scan.data      = running && in_bits && sreg[hop_tx_pkg::HOP_CODE_W-1];
  assign scan.load_chip = running && (step == hop_tx_pkg::SCAN_BIT_STEPS);

endmodule

// File: design/tick_divider.sv
`timescale 1ns/10ps

module tick_divider (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  logic [hop_tx_pkg::DIV_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      tick <= (cnt == hop_tx_pkg::DIV_LAST);
      if (cnt == hop_tx_pkg::DIV_LAST) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// File: design/scan_bus_if.sv
`timescale 1ns/10ps

interface scan_bus_if;
  logic id;        // high for the whole transfer.
  logic phi;
  logic phi_bar;
  logic data;
  logic load_chip;

  modport driver (
    output id, phi, phi_bar, data, load_chip
  );

  modport pins (
    input id, phi, phi_bar, data, load_chip
  );

endinterface

// File: design/hop_tx_pkg.sv
package hop_tx_pkg;

  localparam int PHASE_W    = 16;
  localparam int SAMPLE_W   = 12;
  localparam int GPIO_W     = 12;
  localparam int NSYMB      = 8;   // symbol 0 is the pilot.
  localparam int SYMB_LEN   = 16;
  localparam int BURST_LEN  = NSYMB * SYMB_LEN;
  localparam int HOP_CODE_W = 16;
  localparam int NUM_HOPS   = 8;
  localparam int HOP_IDX_W  = 3;

  localparam int SYNC_LEN     = 32;
  localparam int LOC_SYNC_LEN = 64;
  localparam int SCAN_DIV     = 4;

  // counter widths and terminal counts.
  localparam int DIV_W        = $clog2(SCAN_DIV);
  localparam int SYNC_CNT_W   = $clog2(LOC_SYNC_LEN);
  localparam int SCAN_STEP_W  = $clog2(HOP_CODE_W * 4 + 4);
  localparam int SAMPLE_IDX_W = $clog2(BURST_LEN);
  localparam int SYMB_IDX_W   = $clog2(NSYMB);
  localparam int SYMB_SHIFT   = $clog2(SYMB_LEN);
  localparam int LUT_W        = 4;

  localparam logic [DIV_W-1:0]        DIV_LAST       = DIV_W'(SCAN_DIV - 1);
  localparam logic [SYNC_CNT_W-1:0]   LOC_SYNC_LAST  = SYNC_CNT_W'(LOC_SYNC_LEN - 1);
  localparam logic [SYNC_CNT_W-1:0]   SYNC_LAST      = SYNC_CNT_W'(SYNC_LEN - 1);
  localparam logic [SCAN_STEP_W-1:0]  SCAN_BIT_STEPS = SCAN_STEP_W'(HOP_CODE_W * 4);
  localparam logic [SCAN_STEP_W-1:0]  SCAN_LAST_STEP = SCAN_STEP_W'(HOP_CODE_W * 4 + 3);
  localparam logic [SAMPLE_IDX_W-1:0] BURST_LAST     = SAMPLE_IDX_W'(BURST_LEN - 1);
  localparam logic [HOP_IDX_W-1:0]    LAST_HOP       = HOP_IDX_W'(NUM_HOPS - 1);
  localparam logic [LUT_W-1:0]        QUARTER_IDX    = LUT_W'(4);

  localparam logic [PHASE_W-1:0] HOP_BASE_INC = 16'd1024;
  localparam logic [PHASE_W-1:0] HOP_STEP_INC = 16'd512;
  localparam logic [PHASE_W-1:0] PILOT_PH     = 16'd16384; // quarter turn.
  localparam logic [PHASE_W-1:0] BIT_PH       = 16'd32768; // half turn.

  localparam logic [GPIO_W-1:0] PIN_SYNC    = 12'h001;
  localparam logic [GPIO_W-1:0] PIN_ARM     = 12'h002;
  localparam logic [GPIO_W-1:0] PIN_LOAD    = 12'h004;
  localparam logic [GPIO_W-1:0] PIN_DATA    = 12'h010;
  localparam logic [GPIO_W-1:0] PIN_PHI_BAR = 12'h040;
  localparam logic [GPIO_W-1:0] PIN_PHI     = 12'h100;
  localparam logic [GPIO_W-1:0] PIN_ID      = 12'h400;
  localparam logic [GPIO_W-1:0] PIN_TX      = 12'h800;
  localparam logic [GPIO_W-1:0] OUT_MASK    = PIN_SYNC | PIN_LOAD | PIN_DATA | PIN_PHI_BAR |
                                              PIN_PHI | PIN_ID | PIN_TX;

  // one full turn of sine, amplitude 2047.
  localparam logic signed [SAMPLE_W-1:0] SINE_LUT [16] = '{
    12'sd0,     12'sd783,   12'sd1447,  12'sd1891,
    12'sd2047,  12'sd1891,  12'sd1447,  12'sd783,
    12'sd0,    -12'sd783,  -12'sd1447, -12'sd1891,
    -12'sd2047, -12'sd1891, -12'sd1447, -12'sd783
  };

  typedef enum logic [1:0] {
    st_init,
    st_loc_sync,
    st_hop_sync,
    st_hop_tx
  } seq_state_t;

endpackage
